// File: verilog/exceptionPkg.sv
`default_nettype none

package exceptionPkg;

  // Core address width
  localparam int AddrWidth = 32;

  // Encoding widths for the enums below
  localparam int StateWidth = 3;
  localparam int VecWidth = 3;
  localparam int PcSelWidth = 2;

  // Exception FSM states
  typedef enum logic [StateWidth-1:0] {
    ready,
    dataAbort2,
    intE,
    intM,
    intW,
    exceptionM,
    exceptionW
  } excState;

  // Vector table index, byte offset is index times four
  // Index 5 is reserved
  typedef enum logic [VecWidth-1:0] {
    resetVec     = 3'd0,
    undefVec     = 3'd1,
    swiVec       = 3'd2,
    prefetchVec  = 3'd3,
    dataAbortVec = 3'd4,
    irqVec       = 3'd6,
    fiqVec       = 3'd7
  } vecCode;

  // PC offset the datapath saves into the link register
  typedef enum logic [PcSelWidth-1:0] {
    pcPlus8 = 2'b00,
    pcPlus0 = 2'b01,
    pcPlus4 = 2'b10
  } pcSel;

endpackage

`default_nettype wire

// File: verilog/excStageIf.sv
`default_nettype none

interface excStageIf;

  // Exception flags carried to W
  logic swiW;
  logic prefetchAbortW;
  logic undefInstrW;

  // Status register enables, delayed one cycle
  logic irqEnSync;
  logic fiqEnSync;

  // A PC write reached W, let D take the new PC
  logic unstallD;

  // Stage register clears from the FSM
  logic clearM;
  logic clearW;

  modport pipe (
    output swiW, prefetchAbortW, undefInstrW,
    output irqEnSync, fiqEnSync, unstallD,
    input  clearM, clearW
  );

  modport fsm (
    output clearM, clearW,
    input  irqEnSync, fiqEnSync, unstallD,
    input  swiW, prefetchAbortW, undefInstrW
  );

  modport vec (
    input swiW, prefetchAbortW, undefInstrW
  );

endinterface

`default_nettype wire

// File: verilog/exceptionPipe.sv
`default_nettype none

module exceptionPipe (
  input  logic    clk,
  input  logic    reset,
  input  logic    undefInstrE,
  input  logic    swiE,
  input  logic    prefetchAbortE,
  input  logic    stallE,
  input  logic    stallM,
  input  logic    stallW,
  input  logic    pcUpdateW,
  input  logic    irqEnabled,
  input  logic    fiqEnabled,
  excStageIf.pipe stage
);

  // Flags of the instruction now in M
  logic swiM;
  logic prefetchAbortM;
  logic undefInstrM;

  // E to M flags
  // Cleared once the FSM has left ready, since an earlier exception won
  always_ff @(posedge clk) begin
    if (reset) begin
      swiM <= 1'b0;
      prefetchAbortM <= 1'b0;
      undefInstrM <= 1'b0;
    end else if (!stallM) begin
      if (stage.clearM) begin
        swiM <= 1'b0;
        prefetchAbortM <= 1'b0;
        undefInstrM <= 1'b0;
      end else begin
        swiM <= swiE;
        prefetchAbortM <= prefetchAbortE;
        undefInstrM <= undefInstrE;
      end
    end
  end

  // M to W flags
  // Only taken while the FSM sits in exceptionM, so CPSR save lines up with W
  always_ff @(posedge clk) begin
    if (reset) begin
      stage.swiW <= 1'b0;
      stage.prefetchAbortW <= 1'b0;
      stage.undefInstrW <= 1'b0;
    end else if (!stallW) begin
      if (stage.clearW) begin
        stage.swiW <= 1'b0;
        stage.prefetchAbortW <= 1'b0;
        stage.undefInstrW <= 1'b0;
      end else begin
        stage.swiW <= swiM;
        stage.prefetchAbortW <= prefetchAbortM;
        stage.undefInstrW <= undefInstrM;
      end
    end
  end

  // Status register updates on the falling edge
  // Move the enables onto the rising edge
  always_ff @(posedge clk) begin
    if (reset) begin
      stage.irqEnSync <= 1'b0;
      stage.fiqEnSync <= 1'b0;
    end else begin
      stage.irqEnSync <= irqEnabled;
      stage.fiqEnSync <= fiqEnabled;
    end
  end

  // PC write in W, frees D so a branch target gets in
  always_ff @(posedge clk) begin
    if (reset) begin
      stage.unstallD <= 1'b0;
    end else if (!stallE) begin
      stage.unstallD <= pcUpdateW;
    end
  end

endmodule

`default_nettype wire

// File: verilog/exceptionFsm.sv
`default_nettype none

module exceptionFsm import exceptionPkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   undefInstrE,
  input  logic   swiE,
  input  logic   prefetchAbortE,
  input  logic   dataAbort,
  input  logic   irq,
  input  logic   fiq,
  input  logic   stallD,
  input  logic   stallE,
  input  logic   stallM,
  input  logic   stallW,
  input  logic   pcWrPendingF,
  excStageIf.fsm stage,
  output logic   flushD,
  output logic   flushE,
  output logic   flushM,
  output logic   flushW,
  output logic   stallDOut,
  output logic   interrupting,
  output logic   dataAbortCycle2,
  output logic   irqAssert,
  output logic   fiqAssert
);

  excState state;
  excState nextState;

  // Flush bits in D, E, M, W order
  logic [3:0] flushVec;

  logic instrException;
  logic interruptPending;

  // Exception raised by the instruction in E
  assign instrException = undefInstrE | swiE | prefetchAbortE;

  // Instruction exceptions take precedence over interrupts
  assign interruptPending = ((fiq & stage.fiqEnSync) | (irq & stage.irqEnSync))
                            & ~instrException;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ready;
    end else begin
      state <= nextState;
    end
  end

  // Next state and flushes, Mealy style
  always_comb begin
    flushVec = 4'b0000;
    nextState = state;
    case (state)
      ready: begin
        if (dataAbort) begin
          // Abort caught in M, throw away everything behind it
          flushVec = 4'b1111;
          nextState = dataAbort2;
        end else if (instrException) begin
          // Caught in E, faulting instruction moves on to save CPSR later
          flushVec = 4'b1110;
          nextState = stallM ? ready : exceptionM;
        end else if (interruptPending) begin
          // Wait for the last good instruction to leave D
          nextState = stallD ? ready : intE;
        end
      end

      // Second abort cycle saves the PC
      dataAbort2: begin
        flushVec = 4'b1011;
        nextState = stallE ? dataAbort2 : ready;
      end

      // Faulting instruction in M
      exceptionM: begin
        flushVec = 4'b0100;
        nextState = stallW ? exceptionM : exceptionW;
      end

      // Faulting instruction in W, vector taken
      exceptionW: begin
        flushVec = 4'b1000;
        nextState = stallE ? exceptionW : ready;
      end

      // Last good instruction in E
      // A pending PC write holds everything until it lands
      intE: begin
        flushVec = 4'b0100;
        if (!interruptPending) begin
          nextState = ready;
        end else if (stallE || pcWrPendingF) begin
          nextState = intE;
        end else begin
          nextState = intM;
        end
      end

      // Last good instruction in M
      intM: begin
        flushVec = 4'b0100;
        if (!interruptPending) begin
          nextState = ready;
        end else begin
          nextState = stallM ? intM : intW;
        end
      end

      // Last good instruction in W, interrupt asserts here
      intW: begin
        flushVec = 4'b1000;
        if (!interruptPending) begin
          nextState = ready;
        end else begin
          nextState = stallW ? intW : ready;
        end
      end

      default: begin
        nextState = ready;
      end
    endcase
  end

  assign {flushD, flushE, flushM, flushW} = flushVec;

  assign interrupting = (state != ready) | instrException;
  assign dataAbortCycle2 = (state == dataAbort2);

  // FIQ wins over IRQ
  assign fiqAssert = (state == intW) & fiq & stage.fiqEnSync;
  assign irqAssert = (state == intW) & irq & stage.irqEnSync & ~fiqAssert;

  // Hold D so the return address stays put
  // Released when a PC write reaches W so the branch target can enter D
  assign stallDOut = (((state == intE) | (state == intM)) & ~stage.unstallD)
                     | ((state == ready) & (dataAbort | instrException))
                     | (state == exceptionM);

  // M flags only survive while idle
  assign stage.clearM = (state != ready);
  // W flags only taken from exceptionM
  assign stage.clearW = (state != exceptionM);

endmodule

`default_nettype wire

// File: verilog/exceptionVector.sv
`default_nettype none

module exceptionVector import exceptionPkg::*; #(
  parameter logic [AddrWidth-1:0] VectorBase = '0
) (
  input  logic                 reset,
  input  logic                 dataAbortCycle2,
  input  logic                 irqAssert,
  input  logic                 fiqAssert,
  excStageIf.vec               stage,
  output logic [AddrWidth-1:0] vectorPc,
  output logic                 savePc,
  output pcSel                 pcInSelect
);

  vecCode code;
  logic [AddrWidth-1:0] vecOffset;

  logic interruptSrc;
  logic instrAbortSrc;

  assign interruptSrc = fiqAssert | irqAssert;

  // Sources that save the faulting PC itself
  assign instrAbortSrc = dataAbortCycle2 | stage.prefetchAbortW | stage.swiW
                         | stage.undefInstrW;

  // Highest priority source first
  always_comb begin
    if (fiqAssert) begin
      code = fiqVec;
    end else if (irqAssert) begin
      code = irqVec;
    end else if (dataAbortCycle2) begin
      code = dataAbortVec;
    end else if (stage.prefetchAbortW) begin
      code = prefetchVec;
    end else if (stage.swiW) begin
      code = swiVec;
    end else if (stage.undefInstrW) begin
      code = undefVec;
    end else begin
      // Reset, and the idle case
      code = resetVec;
    end
  end

  // Four bytes per vector entry
  assign vecOffset = {{(AddrWidth - VecWidth - 2){1'b0}}, code, 2'b00};
  assign vectorPc = VectorBase + vecOffset;

  assign savePc = interruptSrc | instrAbortSrc | reset;

  always_comb begin
    if (interruptSrc) begin
      pcInSelect = pcPlus4;
    end else if (instrAbortSrc) begin
      pcInSelect = pcPlus0;
    end else begin
      pcInSelect = pcPlus8;
    end
  end

endmodule

`default_nettype wire

// File: verilog/exceptionUnit.sv
`default_nettype none

module exceptionUnit import exceptionPkg::*; #(
  // Low vectors, a high-vector core uses 32'hFFFF_0000
  parameter logic [AddrWidth-1:0] VectorBase = 32'h0000_0000
) (
  input  logic                 clk,
  input  logic                 reset,
  // Exceptions with the instruction in E
  input  logic                 undefInstrE,
  input  logic                 swiE,
  input  logic                 prefetchAbortE,
  // Abort from the data side, caught in M
  input  logic                 dataAbort,
  // Interrupt request levels and their status register enables
  input  logic                 irq,
  input  logic                 fiq,
  input  logic                 irqEnabled,
  input  logic                 fiqEnabled,
  // Pipeline stalls
  input  logic                 stallD,
  input  logic                 stallE,
  input  logic                 stallM,
  input  logic                 stallW,
  input  logic                 pcWrPendingF,
  input  logic                 pcUpdateW,
  // Pipeline control
  output logic                 flushD,
  output logic                 flushE,
  output logic                 flushM,
  output logic                 flushW,
  output logic                 stallDOut,
  output logic                 interrupting,
  output logic                 dataAbortCycle2,
  output logic                 irqAssert,
  output logic                 fiqAssert,
  output logic                 resetMicrop,
  // PC vectoring
  output logic [AddrWidth-1:0] vectorPc,
  output logic                 savePc,
  output pcSel                 pcInSelect
);

  excStageIf stage ();

  // Stage carry of flags, enable sync, PC write tracking
  exceptionPipe i_pipe (
    .clk            (clk),
    .reset          (reset),
    .undefInstrE    (undefInstrE),
    .swiE           (swiE),
    .prefetchAbortE (prefetchAbortE),
    .stallE         (stallE),
    .stallM         (stallM),
    .stallW         (stallW),
    .pcUpdateW      (pcUpdateW),
    .irqEnabled     (irqEnabled),
    .fiqEnabled     (fiqEnabled),
    .stage          (stage)
  );

  exceptionFsm i_fsm (
    .clk             (clk),
    .reset           (reset),
    .undefInstrE     (undefInstrE),
    .swiE            (swiE),
    .prefetchAbortE  (prefetchAbortE),
    .dataAbort       (dataAbort),
    .irq             (irq),
    .fiq             (fiq),
    .stallD          (stallD),
    .stallE          (stallE),
    .stallM          (stallM),
    .stallW          (stallW),
    .pcWrPendingF    (pcWrPendingF),
    .stage           (stage),
    .flushD          (flushD),
    .flushE          (flushE),
    .flushM          (flushM),
    .flushW          (flushW),
    .stallDOut       (stallDOut),
    .interrupting    (interrupting),
    .dataAbortCycle2 (dataAbortCycle2),
    .irqAssert       (irqAssert),
    .fiqAssert       (fiqAssert)
  );

  exceptionVector #(
    .VectorBase (VectorBase)
  ) i_vector (
    .reset           (reset),
    .dataAbortCycle2 (dataAbortCycle2),
    .irqAssert       (irqAssert),
    .fiqAssert       (fiqAssert),
    .stage           (stage),
    .vectorPc        (vectorPc),
    .savePc          (savePc),
    .pcInSelect      (pcInSelect)
  );

  // Data abort kills the running micro-op sequence too
  assign resetMicrop = dataAbort;

endmodule

`default_nettype wire

// File: bench/clockGen.sv
`default_nettype none

module clockGen #(
  parameter int Period = 20,
  parameter int ResetCycles = 8
) (
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 100ps;

  // Free running clock, low for the first half period
  initial begin
    clk = 1'b0;
    forever #(Period / 2) clk = ~clk;
  end

  // Reset held over the first rising edges, released just after the last one
  initial begin
    reset = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

// File: bench/exceptionUnitTb.sv
`default_nettype none

module exceptionUnitTb import exceptionPkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ClkPeriod = 20;
  localparam int ResetCycles = 8;
  // Spare cycles on top of the trace length
  localparam int WatchdogMargin = 20;
  localparam logic [AddrWidth-1:0] VecBase = 32'h0000_0000;

  logic clk;
  logic reset;

  // DUT inputs
  logic undefInstrE;
  logic swiE;
  logic prefetchAbortE;
  logic dataAbort;
  logic irq;
  logic fiq;
  logic irqEnabled;
  logic fiqEnabled;
  logic stallD;
  logic stallE;
  logic stallM;
  logic stallW;
  logic pcWrPendingF;
  logic pcUpdateW;

  // DUT outputs
  logic flushD;
  logic flushE;
  logic flushM;
  logic flushW;
  logic stallDOut;
  logic interrupting;
  logic dataAbortCycle2;
  logic irqAssert;
  logic fiqAssert;
  logic resetMicrop;
  logic [AddrWidth-1:0] vectorPc;
  logic savePc;
  pcSel pcInSelect;

  // Trace text, one entry per file line
  string traceLines[$];
  int traceLength = 0;
  int fd;

  // Fields of the current data line
  logic expReset;
  logic [2:0] excBits;
  logic dabtBit;
  logic [1:0] intReq;
  logic [1:0] intEn;
  logic [3:0] stallBits;
  logic pendBit;
  logic updBit;
  logic [3:0] expFlush;
  logic expStallD;
  logic expDac2;
  logic [1:0] expAssert;
  logic expMicrop;
  logic expSavePc;
  logic [AddrWidth-1:0] expOffset;
  int expPcOffset;

  // Bookkeeping
  string testName = "";
  int lineNo = 0;
  int testCount = 0;
  int testCycles = 0;
  int testErrors = 0;
  int checkCount = 0;
  int errorCount = 0;

  clockGen #(
    .Period      (ClkPeriod),
    .ResetCycles (ResetCycles)
  ) i_clock (
    .clk   (clk),
    .reset (reset)
  );

  exceptionUnit #(
    .VectorBase (VecBase)
  ) i_dut (
    .clk             (clk),
    .reset           (reset),
    .undefInstrE     (undefInstrE),
    .swiE            (swiE),
    .prefetchAbortE  (prefetchAbortE),
    .dataAbort       (dataAbort),
    .irq             (irq),
    .fiq             (fiq),
    .irqEnabled      (irqEnabled),
    .fiqEnabled      (fiqEnabled),
    .stallD          (stallD),
    .stallE          (stallE),
    .stallM          (stallM),
    .stallW          (stallW),
    .pcWrPendingF    (pcWrPendingF),
    .pcUpdateW       (pcUpdateW),
    .flushD          (flushD),
    .flushE          (flushE),
    .flushM          (flushM),
    .flushW          (flushW),
    .stallDOut       (stallDOut),
    .interrupting    (interrupting),
    .dataAbortCycle2 (dataAbortCycle2),
    .irqAssert       (irqAssert),
    .fiqAssert       (fiqAssert),
    .resetMicrop     (resetMicrop),
    .vectorPc        (vectorPc),
    .savePc          (savePc),
    .pcInSelect      (pcInSelect)
  );

  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    checkCount++;
    if (actual !== expected) begin
      $display("** Error: test %s line %0d %s expected %0h actual %0h",
               testName, lineNo, what, expected, actual);
      errorCount++;
      testErrors++;
    end
  endtask

  task automatic finishTest();
    $display("Test %s: %0d cycles, %0d errors", testName, testCycles, testErrors);
  endtask

  // One trace cycle, driven on the falling edge, sampled just before the rising one
  task automatic playCycle();
    pcSel expSel;
    logic expBusy;
    @(negedge clk);
    if (!expReset) begin
      while (reset) @(negedge clk);
    end else if (!reset) begin
      $display("Trace line %0d expects reset high, but reset was already released", lineNo);
      errorCount++;
      testErrors++;
    end
    {undefInstrE, swiE, prefetchAbortE} = excBits;
    dataAbort = dabtBit;
    {irq, fiq} = intReq;
    {irqEnabled, fiqEnabled} = intEn;
    {stallD, stallE, stallM, stallW} = stallBits;
    pcWrPendingF = pendBit;
    pcUpdateW = updBit;
    #(ClkPeriod / 2 - 1);
    // Trace gives the saved PC offset in bytes
    case (expPcOffset)
      0: expSel = pcPlus0;
      4: expSel = pcPlus4;
      default: expSel = pcPlus8;
    endcase
    // Every state but ready flushes some stage
    // A fresh data abort flushes from ready and is not yet busy
    // An instruction exception in E counts at once
    expBusy = (excBits != 3'b000) | ((expFlush != 4'b0000) & !dabtBit);
    checkValue("flush DEMW", expFlush, {flushD, flushE, flushM, flushW});
    checkValue("stallD", expStallD, stallDOut);
    checkValue("interrupting", expBusy, interrupting);
    checkValue("dataAbortCycle2", expDac2, dataAbortCycle2);
    checkValue("irqAssert fiqAssert", expAssert, {irqAssert, fiqAssert});
    checkValue("resetMicrop", expMicrop, resetMicrop);
    checkValue("savePc", expSavePc, savePc);
    checkValue("vectorPc", VecBase + expOffset, vectorPc);
    checkValue("pcInSelect", expSel, pcInSelect);
    testCycles++;
  endtask

  task automatic runTrace();
    string textLine;
    string nextName;
    int fields;
    int i;
    for (i = 0; i < traceLines.size(); i++) begin
      textLine = traceLines[i];
      lineNo = i + 1;
      if (textLine.len() < 2 || textLine.substr(0, 0) == "#") begin
        continue;
      end
      if (textLine.substr(0, 4) == "test ") begin
        void'($sscanf(textLine, "test %s", nextName));
        if (testName != "") begin
          finishTest();
        end
        testName = nextName;
        testCycles = 0;
        testErrors = 0;
        testCount++;
      end else begin
        fields = $sscanf(textLine, "%b %b %b %b %b %b %b %b %b %b %b %b %b %b %h %d",
                         expReset, excBits, dabtBit, intReq, intEn, stallBits, pendBit,
                         updBit, expFlush, expStallD, expDac2, expAssert, expMicrop,
                         expSavePc, expOffset, expPcOffset);
        if (fields != 16) begin
          $display("Trace line %0d could not be read as a data line", lineNo);
          errorCount++;
          testErrors++;
        end else begin
          playCycle();
        end
      end
    end
    if (testName != "") begin
      finishTest();
    end
  endtask

  initial begin
    undefInstrE = 1'b0;
    swiE = 1'b0;
    prefetchAbortE = 1'b0;
    dataAbort = 1'b0;
    irq = 1'b0;
    fiq = 1'b0;
    irqEnabled = 1'b0;
    fiqEnabled = 1'b0;
    stallD = 1'b0;
    stallE = 1'b0;
    stallM = 1'b0;
    stallW = 1'b0;
    pcWrPendingF = 1'b0;
    pcUpdateW = 1'b0;
    fd = $fopen("bench/exceptionTrace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file bench/exceptionTrace.txt");
      $display("Checks failed");
    end else begin
      while (!$feof(fd)) begin
        string lineBuf;
        if ($fgets(lineBuf, fd) != 0) begin
          traceLines.push_back(lineBuf);
        end
      end
      $fclose(fd);
      traceLength = traceLines.size();
      runTrace();
      $display("Done: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
      if (errorCount == 0) begin
        $display("All checks passed");
      end else begin
        $display("Checks failed");
      end
    end
    $finish;
  end

  // Watchdog, budget is one clock per trace line plus reset and a margin
  initial begin
    wait (traceLength > 0);
    #((traceLength + ResetCycles + WatchdogMargin) * ClkPeriod);
    $display("Timeout: the trace of %0d lines did not finish in time", traceLength);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/exceptionTrace.txt
# rst exc(undef swi pabt) dabt req(irq fiq) en(irq fiq) stall(D E M W) pcWrPendF pcUpdW
#   then expected: flush(D E M W) stallD dabtCyc2 assert(irq fiq) resetMicrop savePc vecOffsetHex pcOffset
test reset
1 000 0 00 00 0000 0 0   0000 0 0 00 0 1 00 8
1 000 0 00 00 0000 0 0   0000 0 0 00 0 1 00 8
0 000 0 00 00 0000 0 0   0000 0 0 00 0 0 00 8
test dataAbort
0 000 1 00 00 0000 0 0   1111 1 0 00 1 0 00 8
0 000 0 00 00 0100 0 0   1011 0 1 00 0 1 10 0
0 000 0 00 00 0000 0 0   1011 0 1 00 0 1 10 0
0 000 0 00 00 0000 0 0   0000 0 0 00 0 0 00 8
test swi
0 010 0 00 00 0000 0 0   1110 1 0 00 0 0 00 8
0 000 0 00 00 0000 0 0   0100 1 0 00 0 0 00 8
0 000 0 00 00 0000 0 0   1000 0 0 00 0 1 08 0
0 000 0 00 00 0000 0 0   0000 0 0 00 0 0 00 8
test undefInstr
0 100 0 00 00 0000 0 0   1110 1 0 00 0 0 00 8
0 000 0 00 00 0000 0 0   0100 1 0 00 0 0 00 8
0 000 0 00 00 0000 0 0   1000 0 0 00 0 1 04 0
0 000 0 00 00 0000 0 0   0000 0 0 00 0 0 00 8
test swiStallW
0 010 0 00 00 0000 0 0   1110 1 0 00 0 0 00 8
0 000 0 00 00 0011 0 0   0100 1 0 00 0 0 00 8
0 000 0 00 00 0000 0 0   0100 1 0 00 0 0 00 8
0 000 0 00 00 0000 0 0   1000 0 0 00 0 1 08 0
0 000 0 00 00 0000 0 0   0000 0 0 00 0 0 00 8
test irq
0 000 0 10 10 0000 0 0   0000 0 0 00 0 0 00 8
0 000 0 10 10 0000 0 0   0000 0 0 00 0 0 00 8
0 000 0 10 10 0000 0 0   0100 1 0 00 0 0 00 8
0 000 0 10 10 0000 0 0   0100 1 0 00 0 0 00 8
0 000 0 10 10 0000 0 0   1000 0 0 10 0 1 18 4
0 000 0 00 00 0000 0 0   0000 0 0 00 0 0 00 8
test irqDisabled
0 000 0 10 00 0000 0 0   0000 0 0 00 0 0 00 8
0 000 0 10 00 0000 0 0   0000 0 0 00 0 0 00 8
test fiqPriority
0 000 0 11 11 0000 0 0   0000 0 0 00 0 0 00 8
0 000 0 11 11 0000 0 0   0000 0 0 00 0 0 00 8
0 000 0 11 11 0000 0 0   0100 1 0 00 0 0 00 8
0 000 0 11 11 0000 0 0   0100 1 0 00 0 0 00 8
0 000 0 11 11 0000 0 0   1000 0 0 01 0 1 1c 4
0 000 0 00 00 0000 0 0   0000 0 0 00 0 0 00 8
test irqCancel
0 000 0 10 10 0000 0 0   0000 0 0 00 0 0 00 8
0 000 0 10 10 0000 0 0   0000 0 0 00 0 0 00 8
0 000 0 10 10 0000 0 0   0100 1 0 00 0 0 00 8
0 000 0 00 10 0000 0 0   0100 1 0 00 0 0 00 8
0 000 0 00 00 0000 0 0   0000 0 0 00 0 0 00 8
0 000 0 00 00 0000 0 0   0000 0 0 00 0 0 00 8

// File: files.f
verilog/exceptionPkg.sv
verilog/excStageIf.sv
verilog/exceptionPipe.sv
verilog/exceptionFsm.sv
verilog/exceptionVector.sv
verilog/exceptionUnit.sv
bench/clockGen.sv
bench/exceptionUnitTb.sv

// File: Bender.yml
package:
  name: exception_unit

sources:
  - verilog/exceptionPkg.sv
  - verilog/excStageIf.sv
  - verilog/exceptionPipe.sv
  - verilog/exceptionFsm.sv
  - verilog/exceptionVector.sv
  - verilog/exceptionUnit.sv
  - target: test
    files:
      - bench/clockGen.sv
      - bench/exceptionUnitTb.sv
